//--- Bender.yml
package:
  name: msx_cart

sources:
  - msx_pkg.sv
  - bus_cycle_decode.sv
  - slot_select.sv
  - mapper_translate.sv
  - bus_isolation.sv
  - addr_demux.sv
  - msx_cart_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_msx_cart.sv

//--- addr_demux.sv
`timescale 1ns/1ps
`default_nettype none

module addr_demux (
    input  wire                        clk_108m,
    input  wire                        bus_reset_n,
    input  wire msx_pkg::bus_cycle_t   cycle_in,
    output logic [1:0]                 msel,
    output logic [msx_pkg::DATA_W-1:0] mp
);

    msx_pkg::demux_state_e      state;
    logic [4:0]                 cnt;      // clocks since the sequence started
    logic [msx_pkg::ADDR_W-1:0] addr_q;   // address being sent
    logic                       low_byte;

    assign mp = low_byte ? addr_q[7:0] : addr_q[msx_pkg::ADDR_W-1 -: msx_pkg::DATA_W];

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state    <= msx_pkg::DMX_IDLE;
            cnt      <= '0;
            addr_q   <= '0;   // matches the reset record of stage 1
            low_byte <= 1'b0;
            msel     <= 2'b00;
        end else begin
            case (state)
                msx_pkg::DMX_IDLE: begin
                    low_byte <= 1'b0;
                    msel     <= 2'b00;
                    if (cycle_in.addr != addr_q) begin
                        addr_q  <= cycle_in.addr;
                        cnt     <= 5'd1;
                        msel[1] <= 1'b1;   // high byte from clock 1
                        state   <= msx_pkg::DMX_LATCH;
                    end
                end
                msx_pkg::DMX_LATCH: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == msx_pkg::DEMUX_T_ON) begin
                        msel[1] <= 1'b0;
                    end
                    if (cnt == msx_pkg::DEMUX_T_ON + msx_pkg::DEMUX_T_PREFETCH) begin
                        low_byte <= 1'b1; // mp settles before msel[0]
                    end
                    if (cnt == msx_pkg::DEMUX_T_ON + 5'd2 * msx_pkg::DEMUX_T_PREFETCH) begin
                        msel[0] <= 1'b1;
                    end
                    if (cnt == 5'd2 * (msx_pkg::DEMUX_T_ON + msx_pkg::DEMUX_T_PREFETCH)) begin
                        msel     <= 2'b00;
                        low_byte <= 1'b0;
                        state    <= msx_pkg::DMX_IDLE;
                    end
                end
                default: state <= msx_pkg::DMX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- bus_cycle_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_decode (
    input  wire                         clk_108m,
    input  wire                         bus_reset_n,
    input  wire [msx_pkg::ADDR_W-1:0]   cpu_addr,
    input  wire [msx_pkg::DATA_W-1:0]   cpu_dout,
    input  wire                         mreq_n,
    input  wire                         iorq_n,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire                         rfsh_n,
    output msx_pkg::bus_cycle_t         cycle
);

    msx_pkg::access_e access;
    logic             refresh;

    assign refresh = ~mreq_n & ~rfsh_n; // mreq during rfsh

    always_comb begin
        access = msx_pkg::ACC_NONE;
        if (!mreq_n) begin
            if (rfsh_n && !rd_n) begin
                access = msx_pkg::ACC_MEM_RD;
            end else if (rfsh_n && !wr_n) begin
                access = msx_pkg::ACC_MEM_WR;
            end
        end else if (!iorq_n) begin
            if (!rd_n) begin
                access = msx_pkg::ACC_IO_RD;
            end else if (!wr_n) begin
                access = msx_pkg::ACC_IO_WR; // int ack has neither strobe
            end
        end
    end

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            cycle <= '0;
        end else begin
            cycle.addr   <= cpu_addr;
            cycle.wdata  <= cpu_dout;
            cycle.access <= access;
            cycle.rfsh   <= refresh;
        end
    end

endmodule

`default_nettype wire

//--- bus_isolation.sv
`timescale 1ns/1ps
`default_nettype none

module bus_isolation (
    input  wire                        clk_108m,
    input  wire                        bus_reset_n,
    input  wire msx_pkg::routed_cycle_t routed_in,
    output logic                       ext_mreq_n,
    output logic                       ext_iorq_n,
    output logic                       ext_rd_n,
    output logic                       ext_wr_n
);

    msx_pkg::iso_state_e state;
    logic [2:0]          cnt;
    logic                ext_tgt;
    logic                rd_req;
    logic                wr_req;
    logic                rd_q;
    logic                wr_q;
    msx_pkg::access_e    access;

    assign access  = routed_in.cycle.access;
    assign ext_tgt = (routed_in.target == msx_pkg::TGT_EXTERNAL);
    assign rd_req  = ext_tgt && (access == msx_pkg::ACC_MEM_RD || access == msx_pkg::ACC_IO_RD);
    assign wr_req  = ext_tgt && (access == msx_pkg::ACC_MEM_WR || access == msx_pkg::ACC_IO_WR);

    // mreq/iorq pass straight through and refresh still goes out
    assign ext_mreq_n = ~(ext_tgt && (access == msx_pkg::ACC_MEM_RD ||
                                      access == msx_pkg::ACC_MEM_WR ||
                                      routed_in.cycle.rfsh));
    assign ext_iorq_n = ~(ext_tgt && (access == msx_pkg::ACC_IO_RD ||
                                      access == msx_pkg::ACC_IO_WR));
    assign ext_rd_n   = rd_q | ~ext_tgt;
    assign ext_wr_n   = wr_q | ~ext_tgt;

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            state <= msx_pkg::ISO_IDLE;
            cnt   <= '0;
            rd_q  <= 1'b1;
            wr_q  <= 1'b1;
        end else begin
            case (state)
                msx_pkg::ISO_IDLE: begin
                    cnt  <= '0;
                    rd_q <= 1'b1;
                    wr_q <= 1'b1;
                    if (rd_req || wr_req) state <= msx_pkg::ISO_ACTIVE;
                end
                msx_pkg::ISO_ACTIVE: begin
                    cnt <= cnt + 3'd1;
                    if (!rd_req && !wr_req) begin
                        state <= msx_pkg::ISO_IDLE; // cycle gone before release
                    end else if (cnt == msx_pkg::ISO_DELAY - 3'd1) begin
                        rd_q  <= ~rd_req;
                        wr_q  <= ~wr_req;
                        state <= msx_pkg::ISO_WAIT;
                    end
                end
                msx_pkg::ISO_WAIT: begin
                    if (!rd_req && !wr_req) begin
                        rd_q  <= 1'b1;
                        wr_q  <= 1'b1;
                        state <= msx_pkg::ISO_IDLE;
                    end
                end
                default: state <= msx_pkg::ISO_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mapper_translate.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_translate (
    input  wire                        clk_108m,
    input  wire                        bus_reset_n,
    input  wire msx_pkg::routed_cycle_t routed_in,
    output msx_pkg::routed_cycle_t     routed_out,
    output msx_pkg::mem_req_t          mem_req,
    input  wire [msx_pkg::DATA_W-1:0]  mem_rdata,
    input  wire [msx_pkg::DATA_W-1:0]  ext_data,
    output logic [msx_pkg::DATA_W-1:0] cpu_din
);

    logic [3:0][msx_pkg::SEG_W-1:0] seg; // one segment per 16 KB page
    logic [1:0]                     page;
    logic                           seg_wr;
    logic                           mapper_hit;

    assign page       = routed_in.cycle.addr[msx_pkg::ADDR_W-1 -: 2];
    assign mapper_hit = (routed_in.target == msx_pkg::TGT_MAPPER);
    assign seg_wr     = (routed_in.cycle.access == msx_pkg::ACC_IO_WR) &&
                        (routed_in.cycle.addr[7:2] == msx_pkg::MAPPER_PORT_HI);

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            seg <= msx_pkg::MAPPER_SEG_RESET;
        end else if (seg_wr) begin
            seg[routed_in.cycle.addr[1:0]] <= routed_in.cycle.wdata; // FCh..FFh
        end
    end

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            routed_out <= '0;
            mem_req    <= '0;
        end else begin
            routed_out       <= routed_in;
            mem_req.map_addr <= {seg[page], routed_in.cycle.addr[msx_pkg::PAGE_OFS_W-1:0]};
            mem_req.rd       <= mapper_hit && (routed_in.cycle.access == msx_pkg::ACC_MEM_RD);
            mem_req.wr       <= mapper_hit && (routed_in.cycle.access == msx_pkg::ACC_MEM_WR);
            mem_req.wdata    <= routed_in.cycle.wdata;
        end
    end

    // read data back to the cpu
    always_comb begin
        case (routed_out.target)
            msx_pkg::TGT_MAPPER:  cpu_din = mem_rdata;
            msx_pkg::TGT_EXP_REG: cpu_din = routed_out.exp_rdback;
            default:              cpu_din = ext_data;
        endcase
    end

endmodule

`default_nettype wire

//--- msx_cart_top.sv
`timescale 1ns/1ps
`default_nettype none

module msx_cart_top (
    input  wire                         clk_108m,
    input  wire                         bus_reset_n,
    // cpu bus, already synchronous
    input  wire [msx_pkg::ADDR_W-1:0]   cpu_addr,
    input  wire [msx_pkg::DATA_W-1:0]   cpu_dout,
    input  wire                         mreq_n,
    input  wire                         iorq_n,
    input  wire                         rd_n,
    input  wire                         wr_n,
    input  wire                         rfsh_n,
    output logic [msx_pkg::DATA_W-1:0]  cpu_din,
    // memory side of the mapper
    output msx_pkg::mem_req_t           mem_req,
    input  wire [msx_pkg::DATA_W-1:0]   mem_rdata,
    // external slot bus
    input  wire [msx_pkg::DATA_W-1:0]   ext_data,
    output logic                        ext_mreq_n,
    output logic                        ext_iorq_n,
    output logic                        ext_rd_n,
    output logic                        ext_wr_n,
    output logic [1:0]                  msel,
    output logic [msx_pkg::DATA_W-1:0]  mp
);

    msx_pkg::bus_cycle_t    cycle;
    msx_pkg::routed_cycle_t routed_s2;
    msx_pkg::routed_cycle_t routed_s3;

    // --------------------------------------------------
    // four stage pipeline
    // --------------------------------------------------
    bus_cycle_decode i_decode (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .rfsh_n(rfsh_n),
        .cycle(cycle)
    );

    slot_select i_slot (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n),
        .cycle_in(cycle), .routed(routed_s2)
    );

    mapper_translate i_mapper (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n),
        .routed_in(routed_s2), .routed_out(routed_s3),
        .mem_req(mem_req), .mem_rdata(mem_rdata), .ext_data(ext_data),
        .cpu_din(cpu_din)
    );

    bus_isolation i_iso (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n), .routed_in(routed_s3),
        .ext_mreq_n(ext_mreq_n), .ext_iorq_n(ext_iorq_n),
        .ext_rd_n(ext_rd_n), .ext_wr_n(ext_wr_n)
    );

    // side branch off stage 1
    addr_demux i_demux (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n),
        .cycle_in(cycle), .msel(msel), .mp(mp)
    );

endmodule

`default_nettype wire

//--- msx_pkg.sv
`default_nettype none

package msx_pkg;

    // --------------------------------------------------
    // bus widths
    // --------------------------------------------------
    localparam int ADDR_W     = 16;
    localparam int DATA_W     = 8;
    localparam int MAP_ADDR_W = 22;
    localparam int SEG_W      = 8;
    localparam int PAGE_OFS_W = 14; // 16 KB page

    // --------------------------------------------------
    // decode constants and timing
    // --------------------------------------------------
    localparam logic [DATA_W-1:0] PPI_PORT_A      = 8'hA8;
    localparam logic [5:0]        MAPPER_PORT_HI  = 6'b111111; // ports FCh..FFh
    localparam logic [ADDR_W-1:0] EXP_SLOT_ADDR   = 16'hFFFF;
    localparam logic [1:0]        MAPPER_SUB_SLOT = 2'd3;

    // page 3 first, page 0 last
    localparam logic [3:0][SEG_W-1:0] MAPPER_SEG_RESET = {8'd0, 8'd1, 8'd2, 8'd3};

    localparam logic [2:0] ISO_DELAY        = 3'd2; // clocks before ext rd/wr
    localparam logic [4:0] DEMUX_T_ON       = 5'd5; // msel pulse width
    localparam logic [4:0] DEMUX_T_PREFETCH = 5'd2; // mp settle time

    typedef enum logic [2:0] {
        ACC_NONE,
        ACC_MEM_RD,
        ACC_MEM_WR,
        ACC_IO_RD,
        ACC_IO_WR
    } access_e;

    typedef enum logic [1:0] {
        TGT_EXTERNAL,
        TGT_EXP_REG,
        TGT_MAPPER,
        TGT_INTERNAL_IO
    } target_e;

    typedef enum logic [1:0] {
        ISO_IDLE,
        ISO_ACTIVE,
        ISO_WAIT
    } iso_state_e;

    typedef enum logic {
        DMX_IDLE,
        DMX_LATCH
    } demux_state_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        access_e           access;
        logic              rfsh;   // dram refresh on the bus
    } bus_cycle_t;

    typedef struct packed {
        bus_cycle_t        cycle;
        target_e           target;
        logic [1:0]        pri_slot;
        logic [DATA_W-1:0] exp_rdback; // inverted FFFFh value
    } routed_cycle_t;

    typedef struct packed {
        logic [MAP_ADDR_W-1:0] map_addr;
        logic                  rd;
        logic                  wr;
        logic [DATA_W-1:0]     wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- slot_select.sv
`timescale 1ns/1ps
`default_nettype none

module slot_select (
    input  wire                     clk_108m,
    input  wire                     bus_reset_n,
    input  wire msx_pkg::bus_cycle_t cycle_in,
    output msx_pkg::routed_cycle_t  routed
);

    logic [msx_pkg::DATA_W-1:0] ppi_port_a; // 2 bits of primary slot per page
    logic [msx_pkg::DATA_W-1:0] exp_slot0;  // 2 bits of sub-slot per page
    logic [1:0]                 page;
    logic [1:0]                 pri_slot;
    logic [1:0]                 sub_slot;
    logic                       is_mem;
    logic                       ffff_hit;
    logic                       ppi_wr;
    logic                       mapper_io_wr;
    msx_pkg::target_e           target;

    assign page     = cycle_in.addr[msx_pkg::ADDR_W-1 -: 2];
    assign pri_slot = ppi_port_a[2*page +: 2];
    assign sub_slot = exp_slot0[2*page +: 2];

    assign is_mem = (cycle_in.access == msx_pkg::ACC_MEM_RD) ||
                    (cycle_in.access == msx_pkg::ACC_MEM_WR);

    // FFFFh is always page 3, so pri_slot is ppi_port_a[7:6] here
    assign ffff_hit = is_mem && (cycle_in.addr == msx_pkg::EXP_SLOT_ADDR) &&
                      (pri_slot == 2'd0);

    assign ppi_wr       = (cycle_in.access == msx_pkg::ACC_IO_WR) &&
                          (cycle_in.addr[7:0] == msx_pkg::PPI_PORT_A);
    assign mapper_io_wr = (cycle_in.access == msx_pkg::ACC_IO_WR) &&
                          (cycle_in.addr[7:2] == msx_pkg::MAPPER_PORT_HI);

    // --------------------------------------------------
    // target choice with the expanded register ahead of the mapper
    // --------------------------------------------------
    always_comb begin
        if (ffff_hit) begin
            target = msx_pkg::TGT_EXP_REG;
        end else if (is_mem && pri_slot == 2'd0 && sub_slot == msx_pkg::MAPPER_SUB_SLOT) begin
            target = msx_pkg::TGT_MAPPER;
        end else if (ppi_wr || mapper_io_wr) begin
            target = msx_pkg::TGT_INTERNAL_IO;
        end else begin
            target = msx_pkg::TGT_EXTERNAL;
        end
    end

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            ppi_port_a <= '0;
            exp_slot0  <= '0;
        end else begin
            if (ppi_wr) begin
                ppi_port_a <= cycle_in.wdata;
            end
            if (ffff_hit && cycle_in.access == msx_pkg::ACC_MEM_WR) begin
                exp_slot0 <= cycle_in.wdata;
            end
        end
    end

    always_ff @(posedge clk_108m or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            routed <= '0;
        end else begin
            routed.cycle      <= cycle_in;
            routed.target     <= target;
            routed.pri_slot   <= pri_slot;
            routed.exp_rdback <= ~exp_slot0; // reads back inverted
        end
    end

endmodule

`default_nettype wire

//--- sources.f
msx_pkg.sv
bus_cycle_decode.sv
slot_select.sv
mapper_translate.sv
bus_isolation.sv
addr_demux.sv
msx_cart_top.sv
tb_clock_gen.sv
tb_msx_cart.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_108m,
    output logic bus_reset_n
);

    initial begin
        clk_108m = 1'b0;
        forever #10 clk_108m = ~clk_108m; // 20 ns period
    end

    initial begin
        bus_reset_n = 1'b0;
        repeat (10) @(posedge clk_108m);
        @(negedge clk_108m);
        bus_reset_n = 1'b1; // released on a falling edge
    end

endmodule

`default_nettype wire

//--- tb_msx_cart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_cart;

    logic                 clk_108m;
    logic                 bus_reset_n;
    logic [15:0]          cpu_addr;
    logic [7:0]           cpu_dout;
    logic                 mreq_n;
    logic                 iorq_n;
    logic                 rd_n;
    logic                 wr_n;
    logic                 rfsh_n;
    logic [7:0]           cpu_din;
    msx_pkg::mem_req_t    mem_req;
    logic [7:0]           mem_rdata;
    logic [7:0]           ext_data;
    logic                 ext_mreq_n;
    logic                 ext_iorq_n;
    logic                 ext_rd_n;
    logic                 ext_wr_n;
    logic [1:0]           msel;
    logic [7:0]           mp;

    int          value_errs;
    int          other_errs;
    int          clk_count;
    int          addr_changes;
    int          hi_pulses;
    int          lo_pulses;
    logic [1:0]  msel_q;
    logic        quiet;       // ext strobes must idle while every target is internal
    // what one cpu cycle saw
    logic        req_seen;
    logic        req_rd;
    logic        req_wr;
    logic [21:0] req_addr;
    logic [7:0]  req_wdata;
    logic [7:0]  din_seen;
    int          rd_low_at;
    int          rd_high_at;

    tb_clock_gen i_clk (.clk_108m(clk_108m), .bus_reset_n(bus_reset_n));

    msx_cart_top i_dut (
        .clk_108m(clk_108m), .bus_reset_n(bus_reset_n),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .rfsh_n(rfsh_n),
        .cpu_din(cpu_din), .mem_req(mem_req), .mem_rdata(mem_rdata),
        .ext_data(ext_data), .ext_mreq_n(ext_mreq_n), .ext_iorq_n(ext_iorq_n),
        .ext_rd_n(ext_rd_n), .ext_wr_n(ext_wr_n), .msel(msel), .mp(mp)
    );

    // --------------------------------------------------
    // bus checks that run all the time
    // --------------------------------------------------
    assert property (@(posedge clk_108m) disable iff (!bus_reset_n) msel != 2'b11)
    else begin
        value_errs++;
        $display("ERR %0t: both msel bits high", $time);
    end

    assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
                     msel[1] |-> mp == cpu_addr[15:8])
    else begin
        value_errs++;
        $display("ERR %0t: mp %0h is not the high byte of %0h", $time, mp, cpu_addr);
    end

    assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
                     msel[0] |-> mp == cpu_addr[7:0])
    else begin
        value_errs++;
        $display("ERR %0t: mp %0h is not the low byte of %0h", $time, mp, cpu_addr);
    end

    assert property (@(posedge clk_108m) disable iff (!bus_reset_n)
                     quiet |-> (ext_mreq_n && ext_iorq_n && ext_rd_n && ext_wr_n))
    else begin
        value_errs++;
        $display("ERR %0t: ext strobe active on an internal cycle", $time);
    end

    always @(negedge clk_108m) begin
        clk_count++;
        if (!bus_reset_n && clk_count > 1) begin
            assert (ext_mreq_n && ext_iorq_n && ext_rd_n && ext_wr_n &&
                    msel == 2'b00 && !mem_req.rd && !mem_req.wr)
            else begin
                value_errs++;
                $display("ERR %0t: outputs not idle during reset", $time);
            end
        end
        if (bus_reset_n) begin
            if (msel[1] && !msel_q[1]) hi_pulses++;
            if (msel[0] && !msel_q[0]) lo_pulses++;
        end
        msel_q = msel;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got == want)
        else begin
            value_errs++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic confirm(input logic cond, input string why);
        assert (cond)
        else begin
            other_errs++;
            $display("%s", why);
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!bus_reset_n && n < 50) begin
            @(negedge clk_108m);
            n++;
        end
        if (!bus_reset_n) abort_run("reset was never released");
    endtask

    // one z80 cycle with strobes held 30 clocks then released for 10
    task automatic cpu_cycle(input msx_pkg::access_e kind, input logic [15:0] addr,
                             input logic [7:0] data);
        int i;
        if (addr != cpu_addr) addr_changes++;
        @(negedge clk_108m);
        cpu_addr   = addr;
        cpu_dout   = data;
        mreq_n     = !(kind == msx_pkg::ACC_MEM_RD || kind == msx_pkg::ACC_MEM_WR);
        iorq_n     = !(kind == msx_pkg::ACC_IO_RD || kind == msx_pkg::ACC_IO_WR);
        rd_n       = !(kind == msx_pkg::ACC_MEM_RD || kind == msx_pkg::ACC_IO_RD);
        wr_n       = !(kind == msx_pkg::ACC_MEM_WR || kind == msx_pkg::ACC_IO_WR);
        req_seen   = 1'b0;
        req_rd     = 1'b0;
        req_wr     = 1'b0;
        rd_low_at  = -1;
        rd_high_at = -1;
        for (i = 0; i < 30; i++) begin
            @(negedge clk_108m);
            if ((mem_req.rd || mem_req.wr) && !req_seen) begin
                req_seen  = 1'b1;
                req_rd    = mem_req.rd;
                req_wr    = mem_req.wr;
                req_addr  = mem_req.map_addr;
                req_wdata = mem_req.wdata;
            end
            if (!ext_rd_n && rd_low_at < 0) rd_low_at = i;
        end
        din_seen = cpu_din;
        mreq_n   = 1'b1;
        iorq_n   = 1'b1;
        rd_n     = 1'b1;
        wr_n     = 1'b1;
        for (i = 0; i < 10; i++) begin
            @(negedge clk_108m);
            if (ext_rd_n && rd_high_at < 0) rd_high_at = i;
        end
    endtask

    initial begin
        #200_000;
        abort_run("simulation ran past its time limit");
    end

    initial begin
        logic [15:0] addr;
        logic [7:0]  data;
        logic [7:0]  exp_val;
        logic [7:0]  rdback_want;
        logic [7:0]  seg_model [4];
        int          p;
        int          round;

        void'($urandom(32'h5392_71d2));
        cpu_addr  = '0;
        cpu_dout  = '0;
        mreq_n    = 1'b1;
        iorq_n    = 1'b1;
        rd_n      = 1'b1;
        wr_n      = 1'b1;
        rfsh_n    = 1'b1;
        mem_rdata = '0;
        ext_data  = '0;
        quiet     = 1'b0;
        seg_model = '{8'd3, 8'd2, 8'd1, 8'd0}; // pages 0..3 after reset

        wait_reset_release();
        repeat (2) @(negedge clk_108m);
        compare_value("idle outputs after reset",
                      {ext_mreq_n, ext_iorq_n, ext_rd_n, ext_wr_n, msel,
                       mem_req.rd, mem_req.wr}, 8'b1111_0000);

        // --------------------------------------------------
        // slot registers and the inverted FFFFh readback
        // --------------------------------------------------
        quiet    = 1'b1;
        ext_data = 8'($urandom);
        exp_val  = 8'($urandom);
        cpu_cycle(msx_pkg::ACC_IO_WR, 16'h00A8, 8'h00);
        cpu_cycle(msx_pkg::ACC_MEM_WR, 16'hFFFF, exp_val);
        cpu_cycle(msx_pkg::ACC_MEM_RD, 16'hFFFF, 8'h00);
        rdback_want = ~exp_val;
        compare_value("FFFFh readback", din_seen, rdback_want);

        // --------------------------------------------------
        // mapper with all pages in sub-slot 3
        // --------------------------------------------------
        cpu_cycle(msx_pkg::ACC_MEM_WR, 16'hFFFF, 8'hFF);
        for (round = 0; round < 2; round++) begin
            for (p = 0; p < 4; p++) begin
                addr = {p[1:0], 14'($urandom)};
                if (addr == 16'hFFFF) addr = 16'hFFFE; // keep off the slot register
                data = 8'($urandom);
                cpu_cycle(msx_pkg::ACC_MEM_WR, addr, data);
                confirm(req_wr && !req_rd, "mapper write did not raise mem_req.wr");
                compare_value("write map_addr", req_addr, {seg_model[p], addr[13:0]});
                compare_value("write data", req_wdata, data);
                mem_rdata = 8'($urandom);
                cpu_cycle(msx_pkg::ACC_MEM_RD, addr, 8'h00);
                confirm(req_rd && !req_wr, "mapper read did not raise mem_req.rd");
                compare_value("read map_addr", req_addr, {seg_model[p], addr[13:0]});
                compare_value("mapper read data", din_seen, mem_rdata);
            end
            if (round == 0) begin
                for (p = 0; p < 4; p++) begin
                    seg_model[p] = 8'($urandom);
                    cpu_cycle(msx_pkg::ACC_IO_WR, {8'h00, 6'b111111, p[1:0]}, seg_model[p]);
                end
            end
        end

        // --------------------------------------------------
        // external read from page 2 in slot 1
        // --------------------------------------------------
        cpu_cycle(msx_pkg::ACC_IO_WR, 16'h00A8, 8'h10);
        quiet    = 1'b0;
        ext_data = 8'($urandom);
        addr     = {2'b10, 14'($urandom)};
        cpu_cycle(msx_pkg::ACC_MEM_RD, addr, 8'h00);
        confirm(rd_low_at >= 0, "ext_rd_n never went low during the external read");
        confirm(!req_seen, "mem_req was raised for an external read");
        compare_value("external read data", din_seen, ext_data);
        confirm(rd_high_at >= 0, "ext_rd_n stayed low after the strobes were released");

        compare_value("msel[1] pulses", hi_pulses, addr_changes);
        compare_value("msel[0] pulses", lo_pulses, addr_changes);

        $display("value errors: %0d, other failures: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
